// ==== flist.f ====
verilog/exc_pkg.sv
verilog/exc_detect.sv
verilog/cp0_regs.sv
verilog/exc_commit.sv
verilog/exc_unit_top.sv
testbench/tb_exc_unit.sv

// ==== testbench/tb_exc_unit.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_exc_unit;

   localparam logic [31:0] EXC_VEC = 32'h8000_0180;
   localparam int N_INST = 100;
   localparam int CYCLE_LIMIT = 40 * N_INST;

   // Flag bit order {store, load, eret, overflow, break, syscall, ri, delay slot}
   localparam logic [7:0] F_RI = 8'h02;
   localparam logic [7:0] F_SYS = 8'h04;
   localparam logic [7:0] F_BRK = 8'h08;
   localparam logic [7:0] F_OV = 8'h10;
   localparam logic [7:0] F_ERET = 8'h20;
   localparam logic [7:0] F_LD = 8'h40;
   localparam logic [7:0] F_ST = 8'h80;

   logic clk, rst, in_valid, in_ready, in_delay_slot, in_ri, in_syscall, in_break;
   logic in_overflow, in_eret, in_load, in_store, out_valid, out_ready, flush, cp0_wr_en;
   logic [31:0] in_pc, in_inst, in_mem_addr, out_pc, out_inst, redirect_pc;
   logic [31:0] cp0_rd_data, cp0_wr_data;
   logic [4:0] cp0_rd_addr, cp0_wr_addr;
   logic [5:0] hw_int;
   exc_pkg::mem_size_e in_mem_size;

   // CP0 reference model and scoreboard state
   logic m_ie, m_exl, m_bd, m_ti, exp_flush, exp_out_valid;
   logic [7:0] m_im, m_ip;
   logic [4:0] m_code;
   logic [31:0] m_epc, m_badvaddr, m_count, m_compare, exp_target, cur_count;
   logic [63:0] retire_q[$];
   int mismatch_count = 0;
   int other_count = 0;
   int cycle_count = 0;
   int rnd;

   exc_unit_top #(.EXC_VECTOR(EXC_VEC)) i_dut (
      .clk(clk),
      .rst(rst),
      .in_valid(in_valid),
      .in_ready(in_ready),
      .in_pc(in_pc),
      .in_inst(in_inst),
      .in_delay_slot(in_delay_slot),
      .in_ri(in_ri),
      .in_syscall(in_syscall),
      .in_break(in_break),
      .in_overflow(in_overflow),
      .in_eret(in_eret),
      .in_load(in_load),
      .in_store(in_store),
      .in_mem_size(in_mem_size),
      .in_mem_addr(in_mem_addr),
      .out_valid(out_valid),
      .out_ready(out_ready),
      .out_pc(out_pc),
      .out_inst(out_inst),
      .flush(flush),
      .redirect_pc(redirect_pc),
      .cp0_rd_addr(cp0_rd_addr),
      .cp0_rd_data(cp0_rd_data),
      .cp0_wr_en(cp0_wr_en),
      .cp0_wr_addr(cp0_wr_addr),
      .cp0_wr_data(cp0_wr_data),
      .hw_int(hw_int)
   );

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   ////////////////////////////////////////////////////////////
   // Reference function and compare task
   ////////////////////////////////////////////////////////////

   // Returns 1 when the instruction traps and gives its code and bad address
   function automatic logic exc_expect(input logic [31:0] pc, input logic [7:0] flg,
         input logic [1:0] size, input logic [31:0] addr, input logic int_pend,
         output logic [4:0] code, output logic [31:0] bad);
      logic mis;
      mis = ((size == exc_pkg::SIZE_HALF) && addr[0]) ||
            ((size == exc_pkg::SIZE_WORD) && (addr[1:0] != 2'b00));
      code = exc_pkg::EXC_INT;
      bad = 32'h0;
      exc_expect = 1'b1;
      if (int_pend) code = exc_pkg::EXC_INT;
      else if (pc[1:0] != 2'b00) begin
         code = exc_pkg::EXC_ADEL;
         bad = pc;
      end
      else if (flg[1]) code = exc_pkg::EXC_RI;
      else if (flg[2]) code = exc_pkg::EXC_SYS;
      else if (flg[3]) code = exc_pkg::EXC_BP;
      else if (flg[4]) code = exc_pkg::EXC_OV;
      else if (flg[6] && mis) begin
         code = exc_pkg::EXC_ADEL;
         bad = addr;
      end
      else if (flg[7] && mis) begin
         code = exc_pkg::EXC_ADES;
         bad = addr;
      end
      else exc_expect = 1'b0;
   endfunction

   task automatic check_value(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
      if (got !== exp) begin
         $display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
         mismatch_count++;
      end
   endtask

   task automatic report_and_finish();
      $display("Errors: %0d mismatches, %0d other failures", mismatch_count, other_count);
      if (mismatch_count == 0 && other_count == 0) begin
         $display("Simulation passed");
      end else begin
         $display("Simulation failed");
      end
      $finish;
   endtask

   ////////////////////////////////////////////////////////////
   // Monitor comparing outcomes against the model each cycle
   ////////////////////////////////////////////////////////////

   always @(posedge clk) begin : monitor
      logic [7:0] flg;
      logic trap, acc, int_pend, ti_next;
      logic [4:0] code;
      logic [31:0] bad;
      logic [63:0] head;
      if (rst) begin
         {m_ie, m_exl, m_bd, m_ti, exp_flush, exp_out_valid} = '0;
         {m_im, m_ip, m_code} = '0;
         {m_epc, m_badvaddr, m_count, m_compare} = '0;
      end else begin
         case (cp0_rd_addr)
            exc_pkg::CP0_BADVADDR: check_value("cp0 badvaddr", cp0_rd_data, m_badvaddr);
            exc_pkg::CP0_COUNT:    check_value("cp0 count", cp0_rd_data, m_count);
            exc_pkg::CP0_COMPARE:  check_value("cp0 compare", cp0_rd_data, m_compare);
            exc_pkg::CP0_EPC:      check_value("cp0 epc", cp0_rd_data, m_epc);
            exc_pkg::CP0_STATUS:
               check_value("cp0 status", cp0_rd_data, {16'h0, m_im, 6'h0, m_exl, m_ie});
            exc_pkg::CP0_CAUSE:
               check_value("cp0 cause", cp0_rd_data,
                           {m_bd, m_ti, 14'h0, m_ip, 1'b0, m_code, 2'b00});
            default: ;
         endcase
         check_value("flush", flush, exp_flush);
         if (exp_flush) check_value("redirect_pc", redirect_pc, exp_target);
         check_value("out_valid", out_valid, exp_out_valid);
         check_value("in_ready", in_ready, !exp_out_valid || out_ready);
         if (out_valid && out_ready) begin
            if (retire_q.size() == 0) begin
               $display("Error at %0t: retired an instruction that was never accepted", $time);
               other_count++;
            end else begin
               head = retire_q.pop_front();
               check_value("out_pc", out_pc, head[63:32]);
               check_value("out_inst", out_inst, head[31:0]);
            end
         end

         // Expected outcome of an accepted instruction
         int_pend = m_ie && !m_exl && (|(m_ip & m_im));
         acc = in_valid && in_ready;
         trap = 1'b0;
         exp_flush = 1'b0;
         if (acc) begin
            flg = {in_store, in_load, in_eret, in_overflow, in_break, in_syscall, in_ri,
                   in_delay_slot};
            trap = exc_expect(in_pc, flg, in_mem_size, in_mem_addr, int_pend, code, bad);
            if (trap) begin
               exp_flush = 1'b1;
               exp_target = EXC_VEC;
            end else if (in_eret) begin
               exp_flush = 1'b1;
               exp_target = m_epc;
            end else begin
               retire_q.push_back({in_pc, in_inst});
            end
         end

         // Retire register holds until the consumer takes it
         if (acc && !trap && !in_eret) begin
            exp_out_valid = 1'b1;
         end else if (out_ready) begin
            exp_out_valid = 1'b0;
         end

         // Model register update for this edge
         ti_next = !(cp0_wr_en && cp0_wr_addr == exc_pkg::CP0_COMPARE) &&
                   ((m_count == m_compare) || m_ti);
         if (cp0_wr_en && cp0_wr_addr == exc_pkg::CP0_STATUS) begin
            m_ie = cp0_wr_data[0];
            m_exl = cp0_wr_data[1];
            m_im = cp0_wr_data[15:8];
         end
         if (cp0_wr_en && cp0_wr_addr == exc_pkg::CP0_COMPARE) m_compare = cp0_wr_data;
         if (trap) begin
            m_exl = 1'b1;
            m_code = code;
            m_bd = in_delay_slot;
            m_epc = in_delay_slot ? in_pc - 32'd4 : in_pc;
            if (code == exc_pkg::EXC_ADEL || code == exc_pkg::EXC_ADES) m_badvaddr = bad;
         end else if (acc && in_eret) begin
            m_exl = 1'b0;
         end
         m_ti = ti_next;
         m_ip = {hw_int[5] | ti_next, hw_int[4:0], 2'b00};
         m_count = m_count + 32'd1;
      end
   end

   always @(posedge clk) begin
      cycle_count++;
      if (cycle_count >= CYCLE_LIMIT) begin
         $display("Timeout after %0d cycles, %0d instructions never retired",
                  cycle_count, retire_q.size());
         other_count++;
         report_and_finish();
      end
   end

   // Random back-pressure on the retire port
   always @(posedge clk) out_ready <= ($urandom_range(3) != 0);

   ////////////////////////////////////////////////////////////
   // Stimulus tasks
   ////////////////////////////////////////////////////////////

   task automatic send_inst(input logic [31:0] pc, input logic [31:0] inst,
         input logic [7:0] flg, input logic [1:0] size, input logic [31:0] addr,
         input logic [4:0] rd);
      in_valid <= 1'b1;
      in_pc <= pc;
      in_inst <= inst;
      {in_store, in_load, in_eret, in_overflow} <= flg[7:4];
      {in_break, in_syscall, in_ri, in_delay_slot} <= flg[3:0];
      in_mem_size <= exc_pkg::mem_size_e'(size);
      in_mem_addr <= addr;
      cp0_rd_addr <= rd;
      @(posedge clk);
      while (!in_ready) @(posedge clk);
   endtask

   task automatic idle(input int n);
      in_valid <= 1'b0;
      repeat (n) @(posedge clk);
   endtask

   task automatic cp0_write(input logic [4:0] addr, input logic [31:0] data);
      in_valid <= 1'b0;
      cp0_wr_en <= 1'b1;
      cp0_wr_addr <= addr;
      cp0_wr_data <= data;
      @(posedge clk);
      cp0_wr_en <= 1'b0;
   endtask

   // Aligned pc and data access with random delay slot and access type
   task automatic send_clean(input logic [4:0] rd);
      logic [31:0] pc, addr;
      logic [1:0] size;
      int r;
      r = $urandom;
      pc = $urandom & 32'hffff_fffc;
      addr = $urandom;
      size = (r[4:3] == 2'd3) ? 2'd2 : r[4:3];
      if (size == 2'd2) addr[1:0] = 2'b00;
      if (size == 2'd1) addr[0] = 1'b0;
      send_inst(pc, $urandom, {r[1:0], 5'b0, r[2]}, size, addr, rd);
   endtask

   // One fault per call followed by reads of Cause, EPC and BadVAddr
   task automatic send_fault(input int kind, input logic ds);
      logic [31:0] pc, addr;
      logic [7:0] flg;
      logic [1:0] size;
      pc = $urandom & 32'hffff_fffc;
      addr = $urandom | 32'h1;
      flg = {7'b0, ds};
      size = 2'd0;
      case (kind)
         0: pc = pc | 32'h2;
         1: flg = flg | F_RI;
         2: flg = flg | F_SYS;
         3: flg = flg | F_BRK;
         4: flg = flg | F_OV;
         5: begin
            flg = flg | F_LD;
            size = 2'd2;
         end
         default: begin
            flg = flg | F_ST;
            size = 2'd1;
         end
      endcase
      send_inst(pc, $urandom, flg, size, addr, exc_pkg::CP0_CAUSE);
      idle(1);
      cp0_rd_addr <= exc_pkg::CP0_EPC;
      @(posedge clk);
      cp0_rd_addr <= exc_pkg::CP0_BADVADDR;
      @(posedge clk);
   endtask

   ////////////////////////////////////////////////////////////
   // Test sequence
   ////////////////////////////////////////////////////////////

   initial begin
      rnd = $urandom(32'h669c_3e99);
      {rst, in_valid, in_delay_slot, in_ri, in_syscall, in_break} = 6'b100000;
      {in_overflow, in_eret, in_load, in_store, out_ready, cp0_wr_en} = '0;
      {in_pc, in_inst, in_mem_addr, cp0_wr_data, cp0_wr_addr} = '0;
      in_mem_size = exc_pkg::SIZE_BYTE;
      cp0_rd_addr = exc_pkg::CP0_STATUS;
      hw_int = 6'h0;
      repeat (8) @(posedge clk);
      rst <= 1'b0;

      // Clean stream under back-pressure
      repeat (60) begin
         send_clean(exc_pkg::CP0_COUNT);
         if ($urandom_range(1)) idle(1);
      end
      idle(2);

      // Single faults outside and inside a delay slot
      for (int k = 0; k < 7; k++) send_fault(k, 1'b0);
      for (int k = 0; k < 7; k++) send_fault(k, 1'b1);

      // Several faults at once resolve by priority
      repeat (20) begin
         rnd = $urandom;
         send_inst((rnd[0] ? 32'h0040_0002 : 32'h0040_0000) + (rnd[15:8] << 2), $urandom,
                   {rnd[7:6], 1'b0, rnd[4:1], rnd[5]}, rnd[17] ? 2'd2 : {1'b0, rnd[16]},
                   $urandom, exc_pkg::CP0_CAUSE);
         idle(2);
      end

      // Interrupt gating by ie, im and exl followed by ERET
      cp0_write(exc_pkg::CP0_STATUS, 32'h0000_0400);
      hw_int <= 6'b000001;
      idle(3);
      send_clean(exc_pkg::CP0_CAUSE);
      hw_int <= 6'b000010;
      cp0_write(exc_pkg::CP0_STATUS, 32'h0000_0401);
      idle(3);
      send_clean(exc_pkg::CP0_CAUSE);
      hw_int <= 6'b000001;
      idle(3);
      send_clean(exc_pkg::CP0_CAUSE);
      idle(2);
      // Line still pending but exl now blocks it
      send_clean(exc_pkg::CP0_STATUS);
      hw_int <= 6'b000000;
      idle(3);
      send_inst(32'h0040_1000, 32'h4200_0018, F_ERET, 2'd0, 32'h0, exc_pkg::CP0_STATUS);
      idle(3);

      // Timer match through Compare
      cp0_rd_addr <= exc_pkg::CP0_COUNT;
      @(posedge clk);
      cur_count = cp0_rd_data;
      cp0_write(exc_pkg::CP0_COMPARE, cur_count + 32'd20);
      cp0_rd_addr <= exc_pkg::CP0_CAUSE;
      @(posedge clk);
      while (cp0_rd_data[30] !== 1'b1) @(posedge clk);
      cp0_write(exc_pkg::CP0_STATUS, 32'h0000_8001);
      idle(2);
      send_clean(exc_pkg::CP0_CAUSE);
      idle(2);
      cp0_write(exc_pkg::CP0_COMPARE, cur_count + 32'h0001_0000);
      idle(3);

      while (retire_q.size() != 0) @(posedge clk);
      idle(3);
      report_and_finish();
   end

endmodule

`default_nettype wire

// ==== verilog/cp0_regs.sv ====
`timescale 1ns/10ps
`default_nettype none

module cp0_regs (
   input  wire                    clk,
   input  wire                    rst,
   input  wire [5:0]              hw_int,
   input  wire [4:0]              rd_addr,
   output logic [31:0]            rd_data,
   input  wire                    wr_en,
   input  wire [4:0]              wr_addr,
   input  wire [31:0]             wr_data,
   input  wire                    exc_take,
   input  wire exc_pkg::exc_code_e exc_take_code,
   input  wire [31:0]             exc_take_epc,
   input  wire                    exc_take_bd,
   input  wire [31:0]             exc_take_badvaddr,
   input  wire                    eret_take,
   output logic [31:0]            epc,
   output logic                   int_pending
);

   exc_pkg::status_u status_r;
   exc_pkg::status_u status_nxt;
   exc_pkg::cause_u  cause_r;
   exc_pkg::cause_u  cause_nxt;
   logic [31:0]      epc_r;
   logic [31:0]      badvaddr_r;
   logic [31:0]      count_r;
   logic [31:0]      compare_r;
   logic             compare_wr;
   logic             ti_nxt;
   logic             adr_err;

   ////////////////////////////////////////////////////////////
   // Timer and interrupt request
   ////////////////////////////////////////////////////////////

   assign compare_wr = wr_en && (wr_addr == exc_pkg::CP0_COMPARE);

   // Timer match is sticky until Compare is rewritten
   assign ti_nxt = !compare_wr && ((count_r == compare_r) || cause_r.f.ti);

   assign int_pending = status_r.f.ie && !status_r.f.exl &&
                        (|(cause_r.f.ip & status_r.f.im));

   assign adr_err = (exc_take_code == exc_pkg::EXC_ADEL) ||
                    (exc_take_code == exc_pkg::EXC_ADES);

   ////////////////////////////////////////////////////////////
   // Status and Cause next state
   ////////////////////////////////////////////////////////////

   always_comb begin
      status_nxt = status_r;
      cause_nxt  = cause_r;

      // Software writes work on the whole word
      if (wr_en && (wr_addr == exc_pkg::CP0_STATUS)) begin
         status_nxt.raw = (status_r.raw & ~exc_pkg::STATUS_WR_MASK) |
                          (wr_data & exc_pkg::STATUS_WR_MASK);
      end
      if (wr_en && (wr_addr == exc_pkg::CP0_CAUSE)) begin
         cause_nxt.raw = (cause_r.raw & ~exc_pkg::CAUSE_WR_MASK) |
                         (wr_data & exc_pkg::CAUSE_WR_MASK);
      end

      // Hardware lines resampled each cycle
      // Timer shares ip[7]
      cause_nxt.f.ti      = ti_nxt;
      cause_nxt.f.ip[7:2] = {hw_int[5] | ti_nxt, hw_int[4:0]};

      // Exception record last so it beats a software write
      if (exc_take) begin
         status_nxt.f.exl   = 1'b1;
         cause_nxt.f.exc_code = exc_take_code;
         cause_nxt.f.bd     = exc_take_bd;
      end else if (eret_take) begin
         status_nxt.f.exl   = 1'b0;
      end
   end

   ////////////////////////////////////////////////////////////
   // Registers
   ////////////////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (rst) begin
         status_r   <= '0;
         cause_r    <= '0;
         epc_r      <= '0;
         badvaddr_r <= '0;
         count_r    <= '0;
         compare_r  <= '0;
      end else begin
         status_r <= status_nxt;
         cause_r  <= cause_nxt;

         if (wr_en && (wr_addr == exc_pkg::CP0_COUNT)) begin
            count_r <= wr_data;
         end else begin
            count_r <= count_r + 32'd1;
         end

         if (compare_wr) begin
            compare_r <= wr_data;
         end

         if (exc_take) begin
            epc_r <= exc_take_epc;
         end else if (wr_en && (wr_addr == exc_pkg::CP0_EPC)) begin
            epc_r <= wr_data;
         end

         // BadVAddr is read only for software
         if (exc_take && adr_err) begin
            badvaddr_r <= exc_take_badvaddr;
         end
      end
   end

   assign epc = epc_r;

   // MFC0 read mux
   always_comb begin
      case (rd_addr)
         exc_pkg::CP0_BADVADDR: rd_data = badvaddr_r;
         exc_pkg::CP0_COUNT:    rd_data = count_r;
         exc_pkg::CP0_COMPARE:  rd_data = compare_r;
         exc_pkg::CP0_STATUS:   rd_data = status_r.raw;
         exc_pkg::CP0_CAUSE:    rd_data = cause_r.raw;
         exc_pkg::CP0_EPC:      rd_data = epc_r;
         default:               rd_data = 32'h0;
      endcase
   end

endmodule

`default_nettype wire

// ==== verilog/exc_commit.sv ====
`timescale 1ns/10ps
`default_nettype none

module exc_commit #(
   parameter logic [31:0] EXC_VECTOR = 32'hbfc0_0380
) (
   input  wire                    clk,
   input  wire                    rst,

   // Upstream from the memory stage
   input  wire                    in_valid,
   output logic                   in_ready,
   input  wire [31:0]             in_pc,
   input  wire [31:0]             in_inst,
   input  wire                    in_delay_slot,
   input  wire                    in_eret,

   // Result of the detector for the current payload
   input  wire                    exc_valid,
   input  wire exc_pkg::exc_code_e exc_code,
   input  wire [31:0]             exc_badvaddr,
   input  wire [31:0]             epc,

   // Retire port
   output logic                   out_valid,
   input  wire                    out_ready,
   output logic [31:0]            out_pc,
   output logic [31:0]            out_inst,

   // Redirect port
   output logic                   flush,
   output logic [31:0]            redirect_pc,

   // Record strobes to CP0
   output logic                   exc_take,
   output exc_pkg::exc_code_e     exc_take_code,
   output logic [31:0]            exc_take_epc,
   output logic                   exc_take_bd,
   output logic [31:0]            exc_take_badvaddr,
   output logic                   eret_take
);

   logic accept;
   logic retire_load;

   ////////////////////////////////////////////////////////////
   // Acceptance and classification
   ////////////////////////////////////////////////////////////

   // Free unless a retired instruction is still waiting
   assign in_ready = !out_valid || out_ready;
   assign accept   = in_valid && in_ready;

   // An exception wins over ERET
   assign exc_take    = accept && exc_valid;
   assign eret_take   = accept && !exc_valid && in_eret;
   assign retire_load = accept && !exc_valid && !in_eret;

   // CP0 writes its record on the acceptance edge
   assign exc_take_code     = exc_code;
   assign exc_take_bd       = in_delay_slot;
   assign exc_take_badvaddr = exc_badvaddr;

   // Delay slot restarts at the branch
   assign exc_take_epc = in_delay_slot ? (in_pc - 32'd4) : in_pc;

   ////////////////////////////////////////////////////////////
   // Control state
   ////////////////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (rst) begin
         out_valid <= 1'b0;
         flush     <= 1'b0;
      end else begin
         // One-cycle pulse after a trap or ERET
         flush <= exc_take || eret_take;

         if (retire_load) begin
            out_valid <= 1'b1;
         end else if (out_ready) begin
            out_valid <= 1'b0;
         end
      end
   end

   ////////////////////////////////////////////////////////////
   // Payload and redirect target
   ////////////////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (retire_load) begin
         out_pc   <= in_pc;
         out_inst <= in_inst;
      end

      if (exc_take) begin
         redirect_pc <= EXC_VECTOR;
      end else if (eret_take) begin
         redirect_pc <= epc;
      end
   end

endmodule

`default_nettype wire

// ==== verilog/exc_detect.sv ====
`timescale 1ns/10ps
`default_nettype none

module exc_detect (
   input  wire [31:0]              pc,
   input  wire                     ri,
   input  wire                     syscall,
   input  wire                     brk,
   input  wire                     overflow,
   input  wire                     load,
   input  wire                     store,
   input  wire exc_pkg::mem_size_e mem_size,
   input  wire [31:0]              mem_addr,
   input  wire                     int_pending,
   output logic                    exc_valid,
   output exc_pkg::exc_code_e      exc_code,
   output logic [31:0]             badvaddr
);

   logic fetch_err;
   logic data_mis;
   logic load_err;
   logic store_err;

   ////////////////////////////////////////////////////////////
   // Alignment checks
   ////////////////////////////////////////////////////////////

   assign fetch_err = (pc[1:0] != 2'b00);

   // Byte accesses are never misaligned
   always_comb begin
      case (mem_size)
         exc_pkg::SIZE_HALF: data_mis = mem_addr[0];
         exc_pkg::SIZE_WORD: data_mis = (mem_addr[1:0] != 2'b00);
         default:            data_mis = 1'b0;
      endcase
   end

   assign load_err  = load && data_mis;
   assign store_err = store && data_mis;

   ////////////////////////////////////////////////////////////
   // Priority encoder
   ////////////////////////////////////////////////////////////

   // Highest priority first
   always_comb begin
      exc_valid = 1'b1;
      exc_code  = exc_pkg::EXC_INT;
      badvaddr  = 32'h0;
      if (int_pending) begin
         exc_code = exc_pkg::EXC_INT;
      end else if (fetch_err) begin
         exc_code = exc_pkg::EXC_ADEL;
         badvaddr = pc;
      end else if (ri) begin
         exc_code = exc_pkg::EXC_RI;
      end else if (syscall) begin
         exc_code = exc_pkg::EXC_SYS;
      end else if (brk) begin
         exc_code = exc_pkg::EXC_BP;
      end else if (overflow) begin
         exc_code = exc_pkg::EXC_OV;
      end else if (load_err) begin
         exc_code = exc_pkg::EXC_ADEL;
         badvaddr = mem_addr;
      end else if (store_err) begin
         exc_code = exc_pkg::EXC_ADES;
         badvaddr = mem_addr;
      end else begin
         exc_valid = 1'b0;
      end
   end

endmodule

`default_nettype wire

// ==== verilog/exc_pkg.sv ====
`default_nettype none

package exc_pkg;

   ////////////////////////////////////////////////////////////
   // Exception codes and CP0 register numbers
   ////////////////////////////////////////////////////////////

   // MIPS ExcCode values, as stored in Cause
   typedef enum logic [4:0] {
      EXC_INT  = 5'd0,
      EXC_ADEL = 5'd4,
      EXC_ADES = 5'd5,
      EXC_SYS  = 5'd8,
      EXC_BP   = 5'd9,
      EXC_RI   = 5'd10,
      EXC_OV   = 5'd12
   } exc_code_e;

   typedef enum logic [4:0] {
      CP0_BADVADDR = 5'd8,
      CP0_COUNT    = 5'd9,
      CP0_COMPARE  = 5'd11,
      CP0_STATUS   = 5'd12,
      CP0_CAUSE    = 5'd13,
      CP0_EPC      = 5'd14
   } cp0_reg_e;

   // Data access size
   typedef enum logic [1:0] {
      SIZE_BYTE = 2'd0,
      SIZE_HALF = 2'd1,
      SIZE_WORD = 2'd2
   } mem_size_e;

   ////////////////////////////////////////////////////////////
   // Cause and Status layouts
   ////////////////////////////////////////////////////////////

   typedef struct packed {
      logic        bd;
      logic        ti;
      logic [13:0] rsvd_hi;
      logic [7:0]  ip;
      logic        rsvd_7;
      exc_code_e   exc_code;
      logic [1:0]  rsvd_lo;
   } cause_fields_t;

   typedef union packed {
      logic [31:0]   raw;
      cause_fields_t f;
   } cause_u;

   typedef struct packed {
      logic [15:0] rsvd_hi;
      logic [7:0]  im;
      logic [5:0]  rsvd_lo;
      logic        exl;
      logic        ie;
   } status_fields_t;

   typedef union packed {
      logic [31:0]    raw;
      status_fields_t f;
   } status_u;

   // Bits that MTC0 may change
   localparam logic [31:0] STATUS_WR_MASK = 32'h0000_ff03;
   // Only the two software interrupt bits in Cause
   localparam logic [31:0] CAUSE_WR_MASK  = 32'h0000_0300;

endpackage

`default_nettype wire

// ==== verilog/exc_unit_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module exc_unit_top #(
   parameter logic [31:0] EXC_VECTOR = 32'hbfc0_0380
) (
   input  wire                    clk,
   input  wire                    rst,

   // Memory stage handshake and payload
   input  wire                    in_valid,
   output wire                    in_ready,
   input  wire [31:0]             in_pc,
   input  wire [31:0]             in_inst,
   input  wire                    in_delay_slot,
   input  wire                    in_ri,
   input  wire                    in_syscall,
   input  wire                    in_break,
   input  wire                    in_overflow,
   input  wire                    in_eret,
   input  wire                    in_load,
   input  wire                    in_store,
   input  wire exc_pkg::mem_size_e in_mem_size,
   input  wire [31:0]             in_mem_addr,

   // Retire port
   output wire                    out_valid,
   input  wire                    out_ready,
   output wire [31:0]             out_pc,
   output wire [31:0]             out_inst,

   // Redirect
   output wire                    flush,
   output wire [31:0]             redirect_pc,

   // CP0 software port and interrupt lines
   input  wire [4:0]              cp0_rd_addr,
   output wire [31:0]             cp0_rd_data,
   input  wire                    cp0_wr_en,
   input  wire [4:0]              cp0_wr_addr,
   input  wire [31:0]             cp0_wr_data,
   input  wire [5:0]              hw_int
);

   logic               exc_valid;
   exc_pkg::exc_code_e exc_code;
   logic [31:0]        exc_badvaddr;
   logic               int_pending;
   logic [31:0]        epc;

   logic               exc_take;
   exc_pkg::exc_code_e exc_take_code;
   logic [31:0]        exc_take_epc;
   logic               exc_take_bd;
   logic [31:0]        exc_take_badvaddr;
   logic               eret_take;

   exc_detect i_detect (
      .pc          (in_pc),
      .ri          (in_ri),
      .syscall     (in_syscall),
      .brk         (in_break),
      .overflow    (in_overflow),
      .load        (in_load),
      .store       (in_store),
      .mem_size    (in_mem_size),
      .mem_addr    (in_mem_addr),
      .int_pending (int_pending),
      .exc_valid   (exc_valid),
      .exc_code    (exc_code),
      .badvaddr    (exc_badvaddr)
   );

   exc_commit #(
      .EXC_VECTOR (EXC_VECTOR)
   ) i_commit (
      .clk               (clk),
      .rst               (rst),
      .in_valid          (in_valid),
      .in_ready          (in_ready),
      .in_pc             (in_pc),
      .in_inst           (in_inst),
      .in_delay_slot     (in_delay_slot),
      .in_eret           (in_eret),
      .exc_valid         (exc_valid),
      .exc_code          (exc_code),
      .exc_badvaddr      (exc_badvaddr),
      .epc               (epc),
      .out_valid         (out_valid),
      .out_ready         (out_ready),
      .out_pc            (out_pc),
      .out_inst          (out_inst),
      .flush             (flush),
      .redirect_pc       (redirect_pc),
      .exc_take          (exc_take),
      .exc_take_code     (exc_take_code),
      .exc_take_epc      (exc_take_epc),
      .exc_take_bd       (exc_take_bd),
      .exc_take_badvaddr (exc_take_badvaddr),
      .eret_take         (eret_take)
   );

   cp0_regs i_cp0 (
      .clk               (clk),
      .rst               (rst),
      .hw_int            (hw_int),
      .rd_addr           (cp0_rd_addr),
      .rd_data           (cp0_rd_data),
      .wr_en             (cp0_wr_en),
      .wr_addr           (cp0_wr_addr),
      .wr_data           (cp0_wr_data),
      .exc_take          (exc_take),
      .exc_take_code     (exc_take_code),
      .exc_take_epc      (exc_take_epc),
      .exc_take_bd       (exc_take_bd),
      .exc_take_badvaddr (exc_take_badvaddr),
      .eret_take         (eret_take),
      .epc               (epc),
      .int_pending       (int_pending)
   );

endmodule

`default_nettype wire
